/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert --timescale 1ns/1ps -j 0
TOP       = imager_tb
FILELIST  = imager.f
OBJDIR    = obj_dir
LOG       = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)
	./$(OBJDIR)/V$(TOP) 2>&1 | tee $(LOG)
	grep -q "Test passed" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)

/* hw/frame_controller.sv */
`timescale 1ns/1ps
`include "imager_macros.svh"

module frame_controller import imager_pkg::*; (
   input  logic                                 clk,
   input  logic                                 reset_n,
   input  logic                                 enable,
   input  raster_pos_t                          pos,
   input  sync_cfg_t                            sync_cfg,
   output frame_state_t                         state,
   output logic [`IMAGER_FRAME_COUNT_WIDTH-1:0] frame_count,
   output logic                                 sync
);

   frame_state_t                state_next;
   logic [`IMAGER_ROWS_WIDTH:0] new_row;
   logic [`IMAGER_ROWS_WIDTH:0] sync_row_end;

   // row the counter moves to on a row wrap inside the frame
   assign new_row      = pos.row + 1'b1;
   assign sync_row_end = sync_cfg.sync_row_start + {1'b0, sync_cfg.sync_rows};

   always_comb begin
      state_next = state;
      case (state)
         st_idle: begin
            state_next = st_active;
         end
         st_active: begin
            // the last active row has wrapped into blanking
            if (!pos.frame_active && !pos.frame_wrap) begin
               state_next = st_vblank;
            end
         end
         st_vblank: begin
            if (pos.frame_wrap) begin
               state_next = st_active;
            end
         end
         default: begin
            state_next = st_idle;
         end
      endcase
      if (!enable) begin
         state_next = st_idle;
      end
   end

   always_ff @(posedge clk or negedge reset_n) begin
      if (!reset_n) begin
         state <= st_idle;
      end else begin
         state <= state_next;
      end
   end

   always_ff @(posedge clk or negedge reset_n) begin
      if (!reset_n) begin
         frame_count <= '0;
      end else if (pos.frame_wrap) begin
         frame_count <= frame_count + 1'b1;
      end
   end

   // exposure sync, active low, moves only on row wraps inside a frame
   always_ff @(posedge clk or negedge reset_n) begin
      if (!reset_n) begin
         sync <= 1'b1;
      end else if (pos.row_wrap && !pos.frame_wrap) begin
         if (new_row == sync_cfg.sync_row_start) begin
            sync <= 1'b0;
         end else if (new_row == sync_row_end) begin
            sync <= 1'b1;
         end
      end
   end

   a_sync_on_row_wrap: assert property (@(posedge clk) disable iff (!reset_n)
      (sync != $past(sync)) |-> $past(pos.row_wrap));

endmodule

/* hw/imager.sv */
`timescale 1ns/1ps
`include "imager_macros.svh"

module imager import imager_pkg::*; (
   input  logic                           clk,
   input  logic                           reset_n,
   input  logic                           enable,
   input  pattern_mode_t                  mode,
   input  raster_cfg_t                    cfg,
   input  sync_cfg_t                      sync_cfg,
   input  bayer_cfg_t                     bayer,
   input  logic [`IMAGER_NOISE_WIDTH-1:0] noise_seed,
   output pixel_out_t                     pixel,
   output logic                           sync
);

   raster_pos_t                          pos;
   frame_state_t                         state;
   logic [`IMAGER_FRAME_COUNT_WIDTH-1:0] frame_count;
   logic [`IMAGER_NOISE_WIDTH-1:0]       noise;

   // position in the raster, shared by every other block
   raster_counter u_raster_counter (
      .clk     (clk),
      .reset_n (reset_n),
      .enable  (enable),
      .cfg     (cfg),
      .pos     (pos)
   );

   frame_controller u_frame_controller (
      .clk         (clk),
      .reset_n     (reset_n),
      .enable      (enable),
      .pos         (pos),
      .sync_cfg    (sync_cfg),
      .state       (state),
      .frame_count (frame_count),
      .sync        (sync)
   );

   noise_lfsr u_noise_lfsr (
      .clk        (clk),
      .reset_n    (reset_n),
      .pos        (pos),
      .noise_seed (noise_seed),
      .noise      (noise)
   );

   pattern_generator u_pattern_generator (
      .clk         (clk),
      .reset_n     (reset_n),
      .enable      (enable),
      .mode        (mode),
      .pos         (pos),
      .state       (state),
      .frame_count (frame_count),
      .noise       (noise),
      .bayer       (bayer),
      .pixel       (pixel)
   );

endmodule

/* hw/imager_macros.svh */
`ifndef IMAGER_MACROS_SVH
`define IMAGER_MACROS_SVH

// pixel sample width on the dat bus
`define IMAGER_DATA_WIDTH 10

// width of the row size inputs, counters carry one extra bit
`define IMAGER_ROWS_WIDTH 12

// width of the column size inputs, counters carry one extra bit
`define IMAGER_COLS_WIDTH 12

// frames seen since reset
`define IMAGER_FRAME_COUNT_WIDTH 16

// noise generator state
`define IMAGER_NOISE_WIDTH 32

`endif

/* hw/imager_pkg.sv */
`include "imager_macros.svh"

package imager_pkg;

   // values from 8 up and the reserved value all give bayer data
   typedef enum logic [3:0] {
      pat_noise       = 4'd0,
      pat_hgrad       = 4'd1,
      pat_vgrad       = 4'd2,
      pat_diag        = 4'd3,
      pat_frame_const = 4'd4,
      pat_frame_diag  = 4'd5,
      pat_reserved    = 4'd6,
      pat_counter     = 4'd7,
      pat_bayer       = 4'd8
   } pattern_mode_t;

   typedef enum logic [1:0] {
      st_idle,
      st_active,
      st_vblank
   } frame_state_t;

   typedef struct packed {
      logic [`IMAGER_ROWS_WIDTH-1:0] num_active_rows;
      logic [`IMAGER_ROWS_WIDTH-1:0] num_virtual_rows;
      logic [`IMAGER_COLS_WIDTH-1:0] num_active_cols;
      logic [`IMAGER_COLS_WIDTH-1:0] num_virtual_cols;
   } raster_cfg_t;

   // sync is low from sync_row_start for sync_rows rows
   typedef struct packed {
      logic [`IMAGER_ROWS_WIDTH:0]   sync_row_start;
      logic [`IMAGER_ROWS_WIDTH-1:0] sync_rows;
   } sync_cfg_t;

   typedef struct packed {
      logic [`IMAGER_DATA_WIDTH-1:0] red;
      logic [`IMAGER_DATA_WIDTH-1:0] gr;
      logic [`IMAGER_DATA_WIDTH-1:0] blue;
      logic [`IMAGER_DATA_WIDTH-1:0] gb;
   } bayer_cfg_t;

   typedef struct packed {
      logic [`IMAGER_ROWS_WIDTH:0] row;
      logic [`IMAGER_COLS_WIDTH:0] col;
      logic                        frame_active;
      logic                        line_active;
      logic                        frame_start;
      logic                        row_wrap;
      logic                        frame_wrap;
   } raster_pos_t;

   typedef struct packed {
      logic [`IMAGER_DATA_WIDTH-1:0] dat;
      logic                          fv;
      logic                          lv;
   } pixel_out_t;

endpackage

/* hw/noise_lfsr.sv */
`timescale 1ns/1ps
`include "imager_macros.svh"

module noise_lfsr import imager_pkg::*; (
   input  logic                           clk,
   input  logic                           reset_n,
   input  raster_pos_t                    pos,
   input  logic [`IMAGER_NOISE_WIDTH-1:0] noise_seed,
   output logic [`IMAGER_NOISE_WIDTH-1:0] noise
);

   logic feedback;
   logic seed_valid;

   // taps 31, 21, 1 and 0, inverted so that all zeros is a legal state
   assign feedback = ~(noise[`IMAGER_NOISE_WIDTH-1] ^ noise[21] ^ noise[1] ^ noise[0]);

   assign seed_valid = |noise_seed;

   always_ff @(posedge clk or negedge reset_n) begin
      if (!reset_n) begin
         noise <= `IMAGER_NOISE_WIDTH'(1);
      end else if (!pos.frame_active) begin
         // a zero seed lets the sequence run on into the next frame
         if (seed_valid) begin
            noise <= noise_seed;
         end
      end else if (pos.line_active) begin
         noise <= {noise[`IMAGER_NOISE_WIDTH-2:0], feedback};
      end
   end

endmodule

/* hw/pattern_generator.sv */
`timescale 1ns/1ps
`include "imager_macros.svh"

module pattern_generator import imager_pkg::*; (
   input  logic                                 clk,
   input  logic                                 reset_n,
   input  logic                                 enable,
   input  pattern_mode_t                        mode,
   input  raster_pos_t                          pos,
   input  frame_state_t                         state,
   input  logic [`IMAGER_FRAME_COUNT_WIDTH-1:0] frame_count,
   input  logic [`IMAGER_NOISE_WIDTH-1:0]       noise,
   input  bayer_cfg_t                           bayer,
   output pixel_out_t                           pixel
);

   logic                          run;
   logic [`IMAGER_DATA_WIDTH-1:0] pixel_count;
   logic [`IMAGER_DATA_WIDTH-1:0] row_lsb;
   logic [`IMAGER_DATA_WIDTH-1:0] col_lsb;
   logic [`IMAGER_DATA_WIDTH-1:0] frame_lsb;
   logic [`IMAGER_DATA_WIDTH-1:0] bayer_value;
   logic [`IMAGER_DATA_WIDTH-1:0] pattern_value;

   // the first enabled cycle is still idle but already sits on row 0 col 0
   assign run = enable && ((state != st_idle) || pos.frame_start);

   // sums are only needed modulo the data width
   assign row_lsb   = pos.row[`IMAGER_DATA_WIDTH-1:0];
   assign col_lsb   = pos.col[`IMAGER_DATA_WIDTH-1:0];
   assign frame_lsb = frame_count[`IMAGER_DATA_WIDTH-1:0];

   // blue on even rows and columns, red on odd rows and columns
   always_comb begin
      case ({pos.row[0], pos.col[0]})
         2'b00:   bayer_value = bayer.blue;
         2'b01:   bayer_value = bayer.gb;
         2'b10:   bayer_value = bayer.gr;
         default: bayer_value = bayer.red;
      endcase
   end

   always_comb begin
      case (mode)
         pat_noise:       pattern_value = noise[`IMAGER_DATA_WIDTH-1:0];
         pat_hgrad:       pattern_value = row_lsb;
         pat_vgrad:       pattern_value = col_lsb;
         pat_diag:        pattern_value = row_lsb + col_lsb;
         pat_frame_const: pattern_value = frame_lsb;
         pat_frame_diag:  pattern_value = frame_lsb + row_lsb + col_lsb;
         pat_counter:     pattern_value = pixel_count;
         default:         pattern_value = bayer_value;
      endcase
   end

   // counts active pixels within one frame
   always_ff @(posedge clk or negedge reset_n) begin
      if (!reset_n) begin
         pixel_count <= '0;
      end else if (!enable || pos.frame_wrap) begin
         pixel_count <= '0;
      end else if (pos.line_active) begin
         pixel_count <= pixel_count + 1'b1;
      end
   end

   always_ff @(posedge clk or negedge reset_n) begin
      if (!reset_n) begin
         pixel <= '0;
      end else if (!run) begin
         pixel <= '0;
      end else begin
         pixel.fv  <= pos.frame_active;
         pixel.lv  <= pos.line_active;
         pixel.dat <= pos.line_active ? pattern_value : '0;
      end
   end

endmodule

/* hw/raster_counter.sv */
`timescale 1ns/1ps
`include "imager_macros.svh"

module raster_counter import imager_pkg::*; (
   input  logic        clk,
   input  logic        reset_n,
   input  logic        enable,
   input  raster_cfg_t cfg,
   output raster_pos_t pos
);

   logic [`IMAGER_ROWS_WIDTH:0]   row;
   logic [`IMAGER_COLS_WIDTH:0]   col;
   logic [`IMAGER_ROWS_WIDTH-1:0] active_rows;
   logic [`IMAGER_COLS_WIDTH-1:0] active_cols;
   logic [`IMAGER_ROWS_WIDTH:0]   next_row;
   logic [`IMAGER_COLS_WIDTH:0]   next_col;
   logic [`IMAGER_ROWS_WIDTH:0]   total_rows;
   logic [`IMAGER_COLS_WIDTH:0]   total_cols;
   logic [`IMAGER_COLS_WIDTH-1:0] hblank_front;
   logic [`IMAGER_COLS_WIDTH:0]   line_end;
   logic                          col_last;
   logic                          row_last;
   logic                          frame_start;

   assign next_row = row + 1'b1;
   assign next_col = col + 1'b1;

   // virtual sizes are taken live, active sizes come from the latch
   assign total_rows = {1'b0, active_rows} + {1'b0, cfg.num_virtual_rows};
   assign total_cols = {1'b0, active_cols} + {1'b0, cfg.num_virtual_cols};

   // half the horizontal blanking sits in front of the active pixels
   assign hblank_front = cfg.num_virtual_cols >> 1;
   assign line_end     = {1'b0, active_cols} + {1'b0, hblank_front};

   assign col_last    = (next_col >= total_cols);
   assign row_last    = (next_row >= total_rows);
   assign frame_start = (row == '0) && (col == '0);

   always_ff @(posedge clk or negedge reset_n) begin
      if (!reset_n) begin
         row         <= '0;
         col         <= '0;
         active_rows <= '0;
         active_cols <= '0;
      end else if (!enable) begin
         row         <= '0;
         col         <= '0;
         active_rows <= cfg.num_active_rows;
         active_cols <= cfg.num_active_cols;
      end else begin
         // sizes only change on a frame boundary
         if (frame_start) begin
            active_rows <= cfg.num_active_rows;
            active_cols <= cfg.num_active_cols;
         end
         if (col_last) begin
            col <= '0;
            row <= row_last ? '0 : next_row;
         end else begin
            col <= next_col;
         end
      end
   end

   assign pos.row          = row;
   assign pos.col          = col;
   // no window and no wraps while stopped
   assign pos.frame_active = enable && (row < {1'b0, active_rows});
   assign pos.line_active  = pos.frame_active && (col >= {1'b0, hblank_front})
                             && (col < line_end);
   assign pos.frame_start  = frame_start;
   assign pos.row_wrap     = enable && col_last;
   assign pos.frame_wrap   = pos.row_wrap && row_last;

   // the row never runs past the last blanking row while running
   a_row_in_frame: assert property (@(posedge clk) disable iff (!reset_n)
      enable |-> (row < total_rows));

   // the column never runs past the end of the row while running
   a_col_in_row: assert property (@(posedge clk) disable iff (!reset_n)
      enable |-> (col < total_cols));

endmodule

/* imager.f */
+incdir+hw
hw/imager_pkg.sv
hw/raster_counter.sv
hw/frame_controller.sv
hw/noise_lfsr.sv
hw/pattern_generator.sv
hw/imager.sv
verification/imager_tb.sv

/* verification/imager_tb.sv */
`timescale 1ns/1ps
`include "imager_macros.svh"

module imager_tb import imager_pkg::*; ();

   localparam int geo_rows     = 6;
   localparam int geo_vrows    = 3;
   localparam int geo_cols     = 8;
   localparam int geo_vcols    = 4;
   localparam int line_cycles  = geo_cols + geo_vcols;
   localparam int frame_cycles = (geo_rows + geo_vrows) * line_cycles;
   localparam int sync_start   = 2;
   localparam int sync_len     = 3;
   // about twenty frames are run in all, restarts and the short frame fit in the margin
   localparam int timeout_cycles = 20 * frame_cycles + 200;

   logic                           clk;
   logic                           reset_n;
   logic                           enable;
   pattern_mode_t                  mode;
   raster_cfg_t                    cfg;
   sync_cfg_t                      sync_cfg;
   bayer_cfg_t                     bayer;
   logic [`IMAGER_NOISE_WIDTH-1:0] noise_seed;
   pixel_out_t                     pixel;
   logic                           sync;

   // values applied on the next rising edge
   logic                           next_enable;
   pattern_mode_t                  next_mode;
   raster_cfg_t                    next_cfg;
   sync_cfg_t                      next_sync_cfg;
   bayer_cfg_t                     next_bayer;
   logic [`IMAGER_NOISE_WIDTH-1:0] next_seed;

   // reference model state
   int                             model_row;
   int                             model_col;
   int                             model_rows_latched;
   int                             model_cols_latched;
   int                             model_frames;
   int                             model_pixels;
   logic [`IMAGER_NOISE_WIDTH-1:0] model_noise;
   pixel_out_t                     exp_pixel;
   logic                           exp_sync;

   pixel_out_t                     obs_pixel;
   logic                           obs_sync;
   string                          test_name = "reset";
   integer                         seed = 32'hcea7;
   int                             cycle_count = 0;

   imager DUT (
      .clk        (clk),
      .reset_n    (reset_n),
      .enable     (enable),
      .mode       (mode),
      .cfg        (cfg),
      .sync_cfg   (sync_cfg),
      .bayer      (bayer),
      .noise_seed (noise_seed),
      .pixel      (pixel),
      .sync       (sync)
   );

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   always @(posedge clk) begin
      cycle_count <= cycle_count + 1;
      if (cycle_count >= timeout_cycles) begin
         $display("Test failed");
         $fatal(1, "no end of tests after %0d cycles", timeout_cycles);
      end
   end

   function automatic raster_cfg_t make_cfg(input int rows, input int vrows, input int cols,
                                            input int vcols);
      raster_cfg_t c;
      c.num_active_rows  = rows[`IMAGER_ROWS_WIDTH-1:0];
      c.num_virtual_rows = vrows[`IMAGER_ROWS_WIDTH-1:0];
      c.num_active_cols  = cols[`IMAGER_COLS_WIDTH-1:0];
      c.num_virtual_cols = vcols[`IMAGER_COLS_WIDTH-1:0];
      return c;
   endfunction

   task automatic fail_with(input string what);
      $display("ERROR in %s: %s", test_name, what);
      $display("Test failed");
      $fatal(1, "stopped at first error");
   endtask

   task automatic compare_pixel(input string name, input pixel_out_t expected,
                                input pixel_out_t actual);
      if (actual !== expected) begin
         $display("FAIL %s: expected fv=%0b lv=%0b dat=%0d, actual fv=%0b lv=%0b dat=%0d",
                  name, expected.fv, expected.lv, expected.dat,
                  actual.fv, actual.lv, actual.dat);
         $display("Test failed");
         $fatal(1, "pixel mismatch");
      end
   endtask

   task automatic compare_sync(input string name, input logic expected, input logic actual);
      if (actual !== expected) begin
         $display("FAIL %s: expected sync=%0b, actual sync=%0b", name, expected, actual);
         $display("Test failed");
         $fatal(1, "sync mismatch");
      end
   endtask

   task automatic compare_count(input string name, input int expected, input int actual);
      if (actual != expected) begin
         $display("FAIL %s: expected %0d, actual %0d", name, expected, actual);
         $display("Test failed");
         $fatal(1, "count mismatch");
      end
   endtask

   function automatic logic [`IMAGER_DATA_WIDTH-1:0] expected_dat(input int row, input int col);
      int v;
      case (mode)
         pat_noise:       v = int'(model_noise[`IMAGER_DATA_WIDTH-1:0]);
         pat_hgrad:       v = row;
         pat_vgrad:       v = col;
         pat_diag:        v = row + col;
         pat_frame_const: v = model_frames;
         pat_frame_diag:  v = model_frames + row + col;
         pat_counter:     v = model_pixels;
         default: begin
            case ({row[0], col[0]})
               2'b00:   v = int'(bayer.blue);
               2'b01:   v = int'(bayer.gb);
               2'b10:   v = int'(bayer.gr);
               default: v = int'(bayer.red);
            endcase
         end
      endcase
      return v[`IMAGER_DATA_WIDTH-1:0];
   endfunction

   // one clock of the raster rules, read with the inputs seen at this edge
   task automatic model_step();
      int front;
      int tot_rows;
      int tot_cols;
      bit f_act;
      bit l_act;
      bit r_wrap;
      bit f_wrap;
      front    = int'(cfg.num_virtual_cols) / 2;
      tot_rows = model_rows_latched + int'(cfg.num_virtual_rows);
      tot_cols = model_cols_latched + int'(cfg.num_virtual_cols);
      f_act    = enable && (model_row < model_rows_latched);
      l_act    = f_act && (model_col >= front) && (model_col < front + model_cols_latched);
      r_wrap   = enable && (model_col + 1 >= tot_cols);
      f_wrap   = r_wrap && (model_row + 1 >= tot_rows);
      exp_pixel = '0;
      if (enable) begin
         exp_pixel.fv  = f_act;
         exp_pixel.lv  = l_act;
         exp_pixel.dat = l_act ? expected_dat(model_row, model_col) : '0;
      end
      if (r_wrap && !f_wrap) begin
         if (model_row + 1 == int'(sync_cfg.sync_row_start)) begin
            exp_sync = 1'b0;
         end else if (model_row + 1 == int'(sync_cfg.sync_row_start)
                      + int'(sync_cfg.sync_rows)) begin
            exp_sync = 1'b1;
         end
      end
      if (f_wrap) model_frames++;
      if (!enable || f_wrap) begin
         model_pixels = 0;
      end else if (l_act) begin
         model_pixels++;
      end
      if (!f_act) begin
         if (noise_seed != '0) model_noise = noise_seed;
      end else if (l_act) begin
         model_noise = {model_noise[`IMAGER_NOISE_WIDTH-2:0],
                        ~(model_noise[`IMAGER_NOISE_WIDTH-1] ^ model_noise[21]
                          ^ model_noise[1] ^ model_noise[0])};
      end
      if (!enable) begin
         model_row          = 0;
         model_col          = 0;
         model_rows_latched = int'(cfg.num_active_rows);
         model_cols_latched = int'(cfg.num_active_cols);
      end else begin
         if (model_row == 0 && model_col == 0) begin
            model_rows_latched = int'(cfg.num_active_rows);
            model_cols_latched = int'(cfg.num_active_cols);
         end
         if (r_wrap) begin
            model_col = 0;
            model_row = f_wrap ? 0 : model_row + 1;
         end else begin
            model_col++;
         end
      end
   endtask

   task automatic tick();
      @(posedge clk);
      model_step();
      enable     <= next_enable;
      mode       <= next_mode;
      cfg        <= next_cfg;
      sync_cfg   <= next_sync_cfg;
      bayer      <= next_bayer;
      noise_seed <= next_seed;
      @(negedge clk);
      compare_pixel(test_name, exp_pixel, pixel);
      compare_sync(test_name, exp_sync, sync);
      obs_pixel = pixel;
      obs_sync  = sync;
   endtask

   // after this the i-th tick shows the pixel of raster position i
   task automatic start_stream(input pattern_mode_t m);
      next_enable = 1'b0;
      tick();
      tick();
      next_mode   = m;
      next_enable = 1'b1;
      tick();
   endtask

   task automatic check_frame_geometry(input int rows, input int vrows, input int cols,
                                       input int vcols);
      int tot_cols;
      int lines;
      int lv_count;
      int fv_count;
      int line_lv;
      bit prev_lv;
      tot_cols = cols + vcols;
      lines    = 0;
      lv_count = 0;
      fv_count = 0;
      line_lv  = 0;
      prev_lv  = 1'b0;
      for (int i = 0; i < (rows + vrows) * tot_cols; i++) begin
         tick();
         if (obs_pixel.lv && !obs_pixel.fv) fail_with("lv is high outside fv");
         if (obs_pixel.fv) fv_count++;
         if (obs_pixel.lv) begin
            if (!prev_lv) begin
               lines++;
               line_lv = 0;
               compare_count(test_name, vcols / 2, i % tot_cols);
            end
            lv_count++;
            line_lv++;
         end else if (prev_lv) begin
            compare_count(test_name, cols, line_lv);
         end
         prev_lv = obs_pixel.lv;
      end
      compare_count(test_name, rows, lines);
      compare_count(test_name, rows * cols, lv_count);
      compare_count(test_name, rows * tot_cols, fv_count);
   endtask

   task automatic check_frame_steps(input string name, input pattern_mode_t m,
                                    input bit add_position);
      int first_value[3];
      int expv;
      test_name = name;
      start_stream(m);
      for (int f = 0; f < 3; f++) begin
         first_value[f] = -1;
         for (int i = 0; i < frame_cycles; i++) begin
            tick();
            if (obs_pixel.lv) begin
               if (first_value[f] < 0) first_value[f] = int'(obs_pixel.dat);
               expv = first_value[f];
               // the first active pixel sits on row 0 behind the front blanking
               if (add_position) begin
                  expv = expv + i / line_cycles + i % line_cycles - geo_vcols / 2;
               end
               compare_count(test_name, expv, int'(obs_pixel.dat));
            end
         end
         if (f > 0) compare_count(test_name, first_value[f-1] + 1, first_value[f]);
      end
   endtask

   task automatic geometry_test();
      test_name = "frame geometry";
      start_stream(pat_hgrad);
      check_frame_geometry(geo_rows, geo_vrows, geo_cols, geo_vcols);
   endtask

   task automatic gradient_test();
      int r;
      int c;
      int expv;
      for (int k = 1; k <= 3; k++) begin
         test_name = (k == 1) ? "horizontal gradient" :
                     (k == 2) ? "vertical gradient" : "diagonal gradient";
         start_stream(pattern_mode_t'(k));
         for (int i = 0; i < frame_cycles; i++) begin
            tick();
            r = i / line_cycles;
            c = i % line_cycles;
            expv = (k == 1) ? r : (k == 2) ? c : r + c;
            if (!obs_pixel.lv) expv = 0;
            compare_count(test_name, expv, int'(obs_pixel.dat));
         end
      end
   endtask

   task automatic frame_mode_test();
      int k;
      check_frame_steps("frame constant", pat_frame_const, 1'b0);
      check_frame_steps("frame diagonal", pat_frame_diag, 1'b1);
      test_name = "pixel counter";
      start_stream(pat_counter);
      for (int f = 0; f < 2; f++) begin
         k = 0;
         for (int i = 0; i < frame_cycles; i++) begin
            tick();
            if (obs_pixel.lv) begin
               compare_count(test_name, k, int'(obs_pixel.dat));
               k++;
            end
         end
         compare_count(test_name, geo_rows * geo_cols, k);
      end
   endtask

   task automatic bayer_test();
      logic [31:0]                   rand_word;
      logic [`IMAGER_DATA_WIDTH-1:0] expv;
      int                            r;
      int                            c;
      rand_word = $random(seed);
      next_bayer.red = rand_word[`IMAGER_DATA_WIDTH-1:0];
      rand_word = $random(seed);
      next_bayer.gr = rand_word[`IMAGER_DATA_WIDTH-1:0];
      rand_word = $random(seed);
      next_bayer.blue = rand_word[`IMAGER_DATA_WIDTH-1:0];
      rand_word = $random(seed);
      next_bayer.gb = rand_word[`IMAGER_DATA_WIDTH-1:0];
      for (int m = 0; m < 2; m++) begin
         test_name = (m == 0) ? "bayer" : "reserved mode";
         start_stream((m == 0) ? pat_bayer : pat_reserved);
         for (int i = 0; i < frame_cycles; i++) begin
            tick();
            r = i / line_cycles;
            c = i % line_cycles;
            if (r % 2 == 0) begin
               expv = (c % 2 == 0) ? next_bayer.blue : next_bayer.gb;
            end else begin
               expv = (c % 2 == 0) ? next_bayer.gr : next_bayer.red;
            end
            if (obs_pixel.lv) compare_count(test_name, int'(expv), int'(obs_pixel.dat));
         end
      end
   endtask

   task automatic noise_test();
      logic [`IMAGER_DATA_WIDTH-1:0] first_frame[geo_rows * geo_cols];
      logic [31:0]                   rand_word;
      int                            k;
      int                            same;
      for (int s = 0; s < 2; s++) begin
         test_name = (s == 0) ? "noise fixed seed" : "noise free running";
         rand_word = $random(seed);
         next_seed = (s == 0) ? (rand_word | 32'h1) : '0;
         start_stream(pat_noise);
         same = 0;
         for (int f = 0; f < 2; f++) begin
            k = 0;
            for (int i = 0; i < frame_cycles; i++) begin
               tick();
               if (obs_pixel.lv) begin
                  if (f == 0) begin
                     first_frame[k] = obs_pixel.dat;
                  end else if (s == 0) begin
                     compare_count(test_name, int'(first_frame[k]), int'(obs_pixel.dat));
                  end else if (first_frame[k] == obs_pixel.dat) begin
                     same++;
                  end
                  k++;
               end
            end
         end
         if (s == 1 && same == geo_rows * geo_cols) fail_with("second noise frame repeats");
      end
   endtask

   task automatic sync_enable_test();
      int low_cycles;
      int first_low;
      test_name = "exposure sync";
      start_stream(pat_hgrad);
      low_cycles = 0;
      first_low  = -1;
      for (int i = 0; i < frame_cycles; i++) begin
         tick();
         if (!obs_sync) begin
            low_cycles++;
            if (first_low < 0) first_low = i;
         end
      end
      // sync moves with the counter, one cycle ahead of the pixel it belongs to
      compare_count(test_name, sync_len * line_cycles, low_cycles);
      compare_count(test_name, sync_start * line_cycles - 1, first_low);
      test_name = "enable";
      repeat (15) tick();
      next_enable = 1'b0;
      next_cfg    = make_cfg(4, 2, 6, 4);
      tick();
      repeat (3) begin
         tick();
         compare_pixel(test_name, pixel_out_t'(0), obs_pixel);
      end
      next_enable = 1'b1;
      tick();
      check_frame_geometry(4, 2, 6, 4);
   endtask

   initial begin
      reset_n            = 1'b0;
      enable             = 1'b0;
      mode               = pat_noise;
      cfg                = make_cfg(geo_rows, geo_vrows, geo_cols, geo_vcols);
      sync_cfg.sync_row_start = sync_start[`IMAGER_ROWS_WIDTH:0];
      sync_cfg.sync_rows      = sync_len[`IMAGER_ROWS_WIDTH-1:0];
      bayer              = '0;
      noise_seed         = '0;
      next_enable        = enable;
      next_mode          = mode;
      next_cfg           = cfg;
      next_sync_cfg      = sync_cfg;
      next_bayer         = bayer;
      next_seed          = noise_seed;
      model_row          = 0;
      model_col          = 0;
      model_rows_latched = 0;
      model_cols_latched = 0;
      model_frames       = 0;
      model_pixels       = 0;
      model_noise        = `IMAGER_NOISE_WIDTH'(1);
      exp_pixel          = '0;
      exp_sync           = 1'b1;
      repeat (2) @(posedge clk);
      reset_n <= 1'b1;
      geometry_test();
      gradient_test();
      frame_mode_test();
      bayer_test();
      noise_test();
      sync_enable_test();
      $display("Test passed");
      $finish;
   end

endmodule
